/* Bender.yml */
package:
  name: tile_video

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/gfx_pkg.sv
      - hdl/video_timer.sv
      - hdl/tile_map_ram.sv
      - hdl/tile_fetch_fsm.sv
      - hdl/tile_line_buffer.sv
      - hdl/color_mixer.sv
      - hdl/video_top.sv
  - target: test
    files:
      - verification/video_asserts.sv
      - verification/video_tb.sv

/* hdl/color_mixer.sv */
// Palette lookup and colour output
`timescale 1ns/100ps
`default_nettype none

module color_mixer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic [gfx_pkg::PXL_W-1:0]   pxl,
    input  logic                        pre_lhbl,
    input  logic                        pre_lvbl,
    input  logic [gfx_pkg::PAL_AW-1:0]  prog_addr,
    input  logic [7:0]                  prog_data,
    input  logic                        prom_en,
    output logic                        lhbl,
    output logic                        lvbl,
    output logic [gfx_pkg::COLOR_W-1:0] red,
    output logic [gfx_pkg::COLOR_W-1:0] green,
    output logic [gfx_pkg::COLOR_W-1:0] blue
);
    import gfx_pkg::*;

    logic [7:0] pal_mem [0:2**PAL_AW-1];
    logic [7:0] rg_byte;
    logic [7:0] b_byte;

    // Two bytes per entry, red and green first
    assign rg_byte = pal_mem[{pxl, 1'b0}];
    assign b_byte  = pal_mem[{pxl, 1'b1}];

    always_ff @(posedge clk) begin
        if (prom_en) begin
            pal_mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            lhbl <= pre_lhbl;
            lvbl <= pre_lvbl;
            if (pre_lhbl && pre_lvbl) begin
                red   <= rg_byte[3:0];
                green <= rg_byte[7:4];
                blue  <= b_byte[3:0];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/gfx_pkg.sv */
// Tile, ROM and palette formats
`default_nettype none

package gfx_pkg;

    localparam int TILE_SIZE = 8;

    // Tile map geometry
    localparam int MAP_COLS  = 4;
    localparam int MAP_ROWS  = 3;
    localparam int MAP_DEPTH = MAP_COLS * MAP_ROWS;
    localparam int MAP_AW    = $clog2(MAP_DEPTH);
    localparam int CODE_W    = 8;

    // Graphics ROM word is one tile row, pixel 0 in the low nibble
    localparam int PXL_W  = 4;
    localparam int ROM_AW = CODE_W + 3;
    localparam int ROM_DW = TILE_SIZE * PXL_W;

    // Outstanding ROM reads
    localparam int ROM_CREDITS = 2;
    localparam int CREDIT_W    = $clog2(ROM_CREDITS + 1);

    localparam int PAL_AW  = 5;
    localparam int COLOR_W = 4;

    typedef enum logic [1:0] {
        IDLE,
        MAP_READ,
        ISSUE,
        DRAIN
    } fetch_state_e;

endpackage

`default_nettype wire

/* hdl/tile_fetch_fsm.sv */
// Tile fetch state machine
`timescale 1ns/100ps
`default_nettype none

module tile_fetch_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       hinit,
    input  logic [video_pkg::V_W-1:0]  vrender,
    input  logic                       flip,
    output logic [gfx_pkg::MAP_AW-1:0] rd_addr,
    input  logic [gfx_pkg::CODE_W-1:0] rd_code,
    output logic                       rom_req,
    output logic [gfx_pkg::ROM_AW-1:0] rom_addr,
    input  logic                       rom_ok,
    output logic                       lb_we,
    output logic [1:0]                 lb_col,
    output logic                       fetch_busy
);
    import video_pkg::*;
    import gfx_pkg::*;

    fetch_state_e        state;
    logic [CREDIT_W-1:0] credits;
    logic [V_W-1:0]      line_sel;
    logic [1:0]          tile_row;
    logic [2:0]          pix_row;
    logic [1:0]          issue_col;
    logic [1:0]          resp_col;
    logic                issue;

    // Vertical mirror of the line about to be drawn
    assign line_sel = flip ? V_W'(V_VISIBLE - 1) - vrender : vrender;

    assign issue      = state == ISSUE && credits != '0;
    assign rom_req    = issue;
    assign rom_addr   = {rd_code, pix_row};
    assign rd_addr    = {tile_row, issue_col};
    assign fetch_busy = state != IDLE;
    assign lb_we      = rom_ok && fetch_busy;
    assign lb_col     = resp_col;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            credits   <= CREDIT_W'(ROM_CREDITS);
            issue_col <= '0;
            resp_col  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Blank lines fall below the map and are skipped
                    if (hinit && line_sel[V_W-1:3] < MAP_ROWS) begin
                        tile_row  <= line_sel[V_W-1:3];
                        pix_row   <= line_sel[2:0];
                        issue_col <= '0;
                        resp_col  <= '0;
                        state     <= MAP_READ;
                    end
                end
                MAP_READ: begin
                    state <= ISSUE;
                end
                ISSUE: begin
                    // Without a credit, wait here for the next rom_ok
                    if (issue) begin
                        issue_col <= issue_col + 1'b1;
                        state     <= (issue_col == 2'(MAP_COLS - 1)) ? DRAIN : MAP_READ;
                    end
                end
                DRAIN: begin
                    if (rom_ok && resp_col == 2'(MAP_COLS - 1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            // Answers come back in order, so a counter gives the column
            if (lb_we) begin
                resp_col <= resp_col + 1'b1;
            end

            case ({issue, rom_ok})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/tile_line_buffer.sv */
// Ping-pong tile line buffer
`timescale 1ns/100ps
`default_nettype none

module tile_line_buffer (
    input  logic                       clk,
    input  logic                       pxl_cen,
    input  logic [video_pkg::V_W-1:0]  vrender,
    input  logic [video_pkg::V_W-1:0]  vdump,
    input  logic [video_pkg::H_W-1:0]  hdump,
    input  logic                       flip,
    input  logic                       lb_we,
    input  logic [1:0]                 lb_col,
    input  logic [gfx_pkg::ROM_DW-1:0] rom_data,
    output logic [gfx_pkg::PXL_W-1:0]  pxl
);
    import video_pkg::*;
    import gfx_pkg::*;

    // Lower half holds even lines, upper half odd lines
    logic [PXL_W-1:0] line_mem [0:2*H_VISIBLE-1];
    logic [4:0]       rd_col;
    logic [5:0]       rd_idx;

    assign rd_col = flip ? ~hdump[4:0] : hdump[4:0];
    assign rd_idx = {vdump[0], rd_col};
    assign pxl    = line_mem[rd_idx];

    always_ff @(posedge clk) begin
        // One ROM word fills a whole tile row
        if (lb_we) begin
            for (int i = 0; i < TILE_SIZE; i++) begin
                line_mem[{vrender[0], lb_col, 3'(i)}] <= rom_data[i*PXL_W +: PXL_W];
            end
        end
        // Erase each pixel once the mixer has taken it
        if (pxl_cen && hdump < H_W'(H_VISIBLE)) begin
            line_mem[rd_idx] <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/tile_map_ram.sv */
// Tile map memory
`timescale 1ns/100ps
`default_nettype none

module tile_map_ram (
    input  logic                        clk,
    input  logic [gfx_pkg::MAP_AW-1:0]  cpu_addr,
    input  logic [gfx_pkg::CODE_W-1:0]  cpu_dout,
    input  logic                        cpu_rnw,
    input  logic                        vram_cs,
    output logic [gfx_pkg::CODE_W-1:0]  vram_dout,
    input  logic [gfx_pkg::MAP_AW-1:0]  rd_addr,
    output logic [gfx_pkg::CODE_W-1:0]  rd_code
);
    import gfx_pkg::*;

    logic [CODE_W-1:0] map_mem [0:MAP_DEPTH-1];

    // CPU side
    always_ff @(posedge clk) begin
        if (vram_cs && !cpu_rnw) begin
            map_mem[cpu_addr] <= cpu_dout;
        end
        if (vram_cs && cpu_rnw) begin
            vram_dout <= map_mem[cpu_addr];
        end
    end

    // Fetcher side
    always_ff @(posedge clk) begin
        rd_code <= map_mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hdl/video_pkg.sv */
// Raster timing constants
`default_nettype none

package video_pkg;

    // Horizontal timing in pixel periods
    localparam int H_TOTAL   = 64;
    localparam int H_VISIBLE = 32;
    localparam int HS_START  = 40;
    localparam int HS_END    = 47;

    // Vertical timing in lines
    localparam int V_TOTAL   = 32;
    localparam int V_VISIBLE = 24;
    localparam int VS_START  = 26;
    localparam int VS_END    = 27;

    // Counter widths
    localparam int H_W = $clog2(H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL);

endpackage

`default_nettype wire

/* hdl/video_timer.sv */
// Raster timer
`timescale 1ns/100ps
`default_nettype none

module video_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    output logic [video_pkg::H_W-1:0] hdump,
    output logic [video_pkg::V_W-1:0] vdump,
    output logic [video_pkg::V_W-1:0] vrender,
    output logic                      hinit,
    output logic                      pre_lhbl,
    output logic                      pre_lvbl,
    output logic                      hs,
    output logic                      vs
);
    import video_pkg::*;

    logic [H_W-1:0] h_next;
    logic [V_W-1:0] v_next;
    logic           line_end;

    assign line_end = hdump == H_W'(H_TOTAL - 1);
    assign h_next   = line_end ? '0 : hdump + 1'b1;
    assign v_next   = !line_end ? vdump :
                      (vdump == V_W'(V_TOTAL - 1)) ? '0 : vdump + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump    <= '0;
            vdump    <= '0;
            vrender  <= V_W'(1);
            hinit    <= 1'b0;
            pre_lhbl <= 1'b0;
            pre_lvbl <= 1'b0;
            hs       <= 1'b0;
            vs       <= 1'b0;
        end else begin
            // Single clock wide even when pxl_cen stays high
            hinit <= pxl_cen && h_next == H_W'(H_VISIBLE);
            if (pxl_cen) begin
                hdump   <= h_next;
                vdump   <= v_next;
                vrender <= (v_next == V_W'(V_TOTAL - 1)) ? '0 : v_next + 1'b1;
                if (h_next == '0) begin
                    pre_lhbl <= 1'b1;
                end else if (h_next == H_W'(H_VISIBLE)) begin
                    pre_lhbl <= 1'b0;
                end
                // Vertical blank only opens at a frame start
                if (line_end) begin
                    if (v_next == '0) begin
                        pre_lvbl <= 1'b1;
                    end else if (v_next == V_W'(V_VISIBLE)) begin
                        pre_lvbl <= 1'b0;
                    end
                end
                hs <= h_next >= H_W'(HS_START) && h_next <= H_W'(HS_END);
                vs <= v_next >= V_W'(VS_START) && v_next <= V_W'(VS_END);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/video_top.sv */
// Tile video top level
`timescale 1ns/100ps
`default_nettype none

module video_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic                        flip,
    input  logic [gfx_pkg::MAP_AW-1:0]  cpu_addr,
    input  logic [gfx_pkg::CODE_W-1:0]  cpu_dout,
    input  logic                        cpu_rnw,
    input  logic                        vram_cs,
    output logic [gfx_pkg::CODE_W-1:0]  vram_dout,
    input  logic [gfx_pkg::PAL_AW-1:0]  prog_addr,
    input  logic [7:0]                  prog_data,
    input  logic                        prom_en,
    output logic                        rom_req,
    output logic [gfx_pkg::ROM_AW-1:0]  rom_addr,
    input  logic [gfx_pkg::ROM_DW-1:0]  rom_data,
    input  logic                        rom_ok,
    output logic                        hs,
    output logic                        vs,
    output logic                        lhbl,
    output logic                        lvbl,
    output logic [gfx_pkg::COLOR_W-1:0] red,
    output logic [gfx_pkg::COLOR_W-1:0] green,
    output logic [gfx_pkg::COLOR_W-1:0] blue
);
    import video_pkg::*;
    import gfx_pkg::*;

    logic [H_W-1:0]    hdump;
    logic [V_W-1:0]    vdump;
    logic [V_W-1:0]    vrender;
    logic              hinit;
    logic              pre_lhbl;
    logic              pre_lvbl;
    logic [MAP_AW-1:0] rd_addr;
    logic [CODE_W-1:0] rd_code;
    logic              lb_we;
    logic [1:0]        lb_col;
    logic [PXL_W-1:0]  pxl;

    video_timer u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .vrender  ( vrender  ),
        .hinit    ( hinit    ),
        .pre_lhbl ( pre_lhbl ),
        .pre_lvbl ( pre_lvbl ),
        .hs       ( hs       ),
        .vs       ( vs       )
    );

    tile_map_ram u_map (
        .clk       ( clk       ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_rnw   ( cpu_rnw   ),
        .vram_cs   ( vram_cs   ),
        .vram_dout ( vram_dout ),
        .rd_addr   ( rd_addr   ),
        .rd_code   ( rd_code   )
    );

    tile_fetch_fsm u_fetch (
        .clk        ( clk      ),
        .rst_n      ( rst_n    ),
        .hinit      ( hinit    ),
        .vrender    ( vrender  ),
        .flip       ( flip     ),
        .rd_addr    ( rd_addr  ),
        .rd_code    ( rd_code  ),
        .rom_req    ( rom_req  ),
        .rom_addr   ( rom_addr ),
        .rom_ok     ( rom_ok   ),
        .lb_we      ( lb_we    ),
        .lb_col     ( lb_col   ),
        .fetch_busy (          )
    );

    tile_line_buffer u_linebuf (
        .clk      ( clk      ),
        .pxl_cen  ( pxl_cen  ),
        .vrender  ( vrender  ),
        .vdump    ( vdump    ),
        .hdump    ( hdump    ),
        .flip     ( flip     ),
        .lb_we    ( lb_we    ),
        .lb_col   ( lb_col   ),
        .rom_data ( rom_data ),
        .pxl      ( pxl      )
    );

    color_mixer u_mixer (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .pxl       ( pxl       ),
        .pre_lhbl  ( pre_lhbl  ),
        .pre_lvbl  ( pre_lvbl  ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prom_en   ( prom_en   ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

endmodule

`default_nettype wire

/* tb.f */
hdl/video_pkg.sv
hdl/gfx_pkg.sv
hdl/video_timer.sv
hdl/tile_map_ram.sv
hdl/tile_fetch_fsm.sv
hdl/tile_line_buffer.sv
hdl/color_mixer.sv
hdl/video_top.sv
verification/video_asserts.sv
verification/video_tb.sv

/* verification/video_asserts.sv */
// Credit link and fetch timing checks
`timescale 1ns/100ps
`default_nettype none

module video_asserts (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         rom_req,
    input logic                         rom_ok,
    input logic [gfx_pkg::CREDIT_W-1:0] credits,
    input logic                         fetch_busy,
    input logic                         pre_lhbl
);
    import gfx_pkg::*;

    int         fail_count = 0;
    logic [2:0] outstanding;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 3'(rom_req) - 3'(rom_ok);
        end
    end

    // A negative count wraps above the limit
    credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CREDIT_W'(ROM_CREDITS))
        else begin
            fail_count++;
            $error("credit count out of range");
        end

    outstanding_max: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= 3'(ROM_CREDITS))
        else begin
            fail_count++;
            $error("too many outstanding ROM requests");
        end

    // Fetch must be over when the next visible line starts
    fetch_done: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pre_lhbl) |-> !fetch_busy)
        else begin
            fail_count++;
            $error("tile fetch still busy at line start");
        end

endmodule

bind video_top video_asserts u_asserts (
    .clk        ( clk                ),
    .rst_n      ( rst_n              ),
    .rom_req    ( rom_req            ),
    .rom_ok     ( rom_ok             ),
    .credits    ( u_fetch.credits    ),
    .fetch_busy ( u_fetch.fetch_busy ),
    .pre_lhbl   ( pre_lhbl           )
);

`default_nettype wire

/* verification/video_tb.sv */
// Tile video testbench
`timescale 1ns/100ps
`default_nettype none

module video_tb;
    import video_pkg::*;
    import gfx_pkg::*;

    localparam int FRAME_CLKS = 2 * H_TOTAL * V_TOTAL;
    localparam int MAX_LAT    = 10;

    logic               clk;
    logic               rst_n;
    logic               pxl_cen;
    logic               flip;
    logic [MAP_AW-1:0]  cpu_addr;
    logic [CODE_W-1:0]  cpu_dout;
    logic               cpu_rnw;
    logic               vram_cs;
    logic [CODE_W-1:0]  vram_dout;
    logic [PAL_AW-1:0]  prog_addr;
    logic [7:0]         prog_data;
    logic               prom_en;
    logic               rom_req;
    logic [ROM_AW-1:0]  rom_addr;
    logic [ROM_DW-1:0]  rom_data;
    logic               rom_ok;
    logic               hs;
    logic               vs;
    logic               lhbl;
    logic               lvbl;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;

    logic [15:0] stim_lfsr;
    logic [15:0] lat_lfsr;

    // Reference copies of the map and the palette
    logic [CODE_W-1:0] map_model [0:MAP_DEPTH-1];
    logic [7:0]        pal_model [0:2**PAL_AW-1];

    // ROM responder state
    logic [ROM_AW-1:0] req_addr_q [$];
    int                req_due_q [$];
    int                cyc;
    int                last_due;
    int                lat;
    int                due;
    logic              req_seen;
    logic [ROM_AW-1:0] addr_seen;
    logic              slow_rom;

    // Raster tracking
    logic             active;
    logic             prev_lhbl;
    logic             prev_lvbl;
    logic             prev_hs;
    logic             prev_vs;
    int               x_pos;
    int               y_pos;
    int               line_pixels;
    int               frame_lines;
    int               hs_width;
    int               vs_width;
    int               hs_pulses;
    int               frames_seen;
    logic [PXL_W-1:0] exp_pxl;
    logic [7:0]       rg_model;
    logic [7:0]       b_model;

    video_top UUT (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .flip      ( flip      ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_rnw   ( cpu_rnw   ),
        .vram_cs   ( vram_cs   ),
        .vram_dout ( vram_dout ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prom_en   ( prom_en   ),
        .rom_req   ( rom_req   ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pixel enable on every other clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(inout logic [15:0] s, input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = (v << 1) | int'(s[0]);
        end
    endtask

    // Nibble i of a ROM word is address plus i, modulo 16
    function automatic logic [ROM_DW-1:0] rom_word(input logic [ROM_AW-1:0] addr);
        logic [ROM_DW-1:0] w;
        for (int i = 0; i < TILE_SIZE; i++) begin
            w[i*PXL_W +: PXL_W] = PXL_W'(int'(addr) + i);
        end
        return w;
    endfunction

    function automatic logic [PXL_W-1:0] model_pixel(input int x, input int y,
                                                     input logic flipped);
        int                xs;
        int                ys;
        logic [CODE_W-1:0] code;
        logic [ROM_DW-1:0] word;
        xs   = flipped ? H_VISIBLE - 1 - x : x;
        ys   = flipped ? V_VISIBLE - 1 - y : y;
        code = map_model[(ys / TILE_SIZE) * MAP_COLS + xs / TILE_SIZE];
        word = rom_word({code, 3'(ys % TILE_SIZE)});
        return word[(xs % TILE_SIZE) * PXL_W +: PXL_W];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH time=%0t signal=%s actual=%0h expected=%0h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic wait_frame_end();
        int   n;
        logic was_visible;
        was_visible = lvbl;
        for (n = 0; n < 2 * FRAME_CLKS; n++) begin
            @(negedge clk);
            if (was_visible && !lvbl) begin
                break;
            end
            was_visible = lvbl;
        end
        if (n == 2 * FRAME_CLKS) begin
            fail_run("Timeout while waiting for the end of a visible frame");
        end
    endtask

    task automatic map_write(input int a, input int v);
        @(posedge clk);
        vram_cs      <= 1'b1;
        cpu_rnw      <= 1'b0;
        cpu_addr     <= MAP_AW'(a);
        cpu_dout     <= CODE_W'(v);
        map_model[a] = CODE_W'(v);
    endtask

    task automatic fill_map();
        int a;
        int v;
        for (a = 0; a < MAP_DEPTH; a++) begin
            draw_bits(stim_lfsr, CODE_W, v);
            map_write(a, v);
        end
        // Some entries are written twice
        repeat (6) begin
            draw_bits(stim_lfsr, 4, a);
            draw_bits(stim_lfsr, CODE_W, v);
            map_write(a % MAP_DEPTH, v);
        end
        @(posedge clk);
        vram_cs <= 1'b0;
    endtask

    task automatic read_map();
        for (int a = 0; a < MAP_DEPTH; a++) begin
            @(posedge clk);
            vram_cs  <= 1'b1;
            cpu_rnw  <= 1'b1;
            cpu_addr <= MAP_AW'(a);
            @(posedge clk);
            vram_cs <= 1'b0;
            @(negedge clk);
            check_value("vram_dout", vram_dout, map_model[a]);
        end
    endtask

    task automatic fill_palette();
        int v;
        for (int a = 0; a < 2**PAL_AW; a++) begin
            draw_bits(stim_lfsr, 8, v);
            @(posedge clk);
            prom_en      <= 1'b1;
            prog_addr    <= PAL_AW'(a);
            prog_data    <= 8'(v);
            pal_model[a] = 8'(v);
        end
        @(posedge clk);
        prom_en <= 1'b0;
    endtask

    // ROM requests are taken where the bus is stable
    always @(negedge clk) begin
        req_seen  = rom_req;
        addr_seen = rom_addr;
    end

    // In-order ROM answers after 1 to MAX_LAT clocks
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (req_seen) begin
            if (slow_rom) begin
                lat = MAX_LAT;
            end else begin
                draw_bits(lat_lfsr, 4, lat);
                lat = 1 + lat % MAX_LAT;
            end
            due = cyc + lat - 1;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            req_addr_q.push_back(addr_seen);
            req_due_q.push_back(due);
        end
        if (req_due_q.size() > 0 && req_due_q[0] <= cyc) begin
            rom_data <= rom_word(req_addr_q.pop_front());
            rom_ok   <= 1'b1;
            void'(req_due_q.pop_front());
        end else begin
            rom_ok <= 1'b0;
        end
    end

    // A new pixel leaves the mixer on every pxl_cen edge
    always @(negedge clk) begin
        if (active && !pxl_cen) begin
            if (UUT.u_asserts.fail_count != 0) begin
                fail_run("A bound assertion on the ROM link or fetch timing failed");
            end
            if (lhbl && !prev_lhbl) begin
                x_pos = 0;
                y_pos = (lvbl && !prev_lvbl) ? 0 : y_pos + 1;
                if (lvbl) begin
                    frame_lines++;
                end
            end else begin
                x_pos++;
            end
            if (lhbl) begin
                line_pixels++;
            end
            if (!lhbl && prev_lhbl) begin
                check_value("visible pixels per line", line_pixels, H_VISIBLE);
                line_pixels = 0;
            end
            if (!lvbl && prev_lvbl) begin
                check_value("visible lines per frame", frame_lines, V_VISIBLE);
                frame_lines = 0;
            end
            if (hs) begin
                hs_width++;
            end
            if (!hs && prev_hs) begin
                check_value("hs width", hs_width, HS_END - HS_START + 1);
                hs_width = 0;
                hs_pulses++;
            end
            // Vertical sync spans whole lines
            if (vs) begin
                vs_width++;
            end
            if (!vs && prev_vs) begin
                check_value("vs width", vs_width, (VS_END - VS_START + 1) * H_TOTAL);
                vs_width = 0;
            end
            if (lvbl && !prev_lvbl) begin
                if (frames_seen > 0) begin
                    check_value("hs pulses per frame", hs_pulses, V_TOTAL);
                end
                hs_pulses = 0;
                frames_seen++;
            end
            if (lhbl && lvbl) begin
                // Entry n occupies bytes 2n and 2n+1
                exp_pxl  = model_pixel(x_pos, y_pos, flip);
                rg_model = pal_model[2 * exp_pxl];
                b_model  = pal_model[2 * exp_pxl + 1];
            end else begin
                rg_model = '0;
                b_model  = '0;
            end
            check_value("red", red, rg_model[3:0]);
            check_value("green", green, rg_model[7:4]);
            check_value("blue", blue, b_model[3:0]);
            prev_lhbl = lhbl;
            prev_lvbl = lvbl;
            prev_hs   = hs;
            prev_vs   = vs;
        end
    end

    initial begin
        rst_n       = 1'b0;
        pxl_cen     = 1'b0;
        flip        = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        cpu_rnw     = 1'b1;
        vram_cs     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        prom_en     = 1'b0;
        rom_data    = '0;
        rom_ok      = 1'b0;
        stim_lfsr   = 16'd10785;
        lat_lfsr    = 16'd10785;
        cyc         = 0;
        last_due    = 0;
        req_seen    = 1'b0;
        addr_seen   = '0;
        slow_rom    = 1'b0;
        active      = 1'b0;
        prev_lhbl   = 1'b0;
        prev_lvbl   = 1'b0;
        prev_hs     = 1'b0;
        prev_vs     = 1'b0;
        x_pos       = 0;
        y_pos       = 0;
        line_pixels = 0;
        frame_lines = 0;
        hs_width    = 0;
        vs_width    = 0;
        hs_pulses   = 0;
        frames_seen = 0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("hs", hs, 1'b0);
        check_value("vs", vs, 1'b0);
        check_value("lhbl", lhbl, 1'b0);
        check_value("lvbl", lvbl, 1'b0);
        check_value("rom_req", rom_req, 1'b0);
        active = 1'b1;

        // First visible frame with random ROM latency
        fill_map();
        read_map();
        fill_palette();
        wait_frame_end();

        // Mirrored picture from a new map
        @(posedge clk);
        flip <= 1'b1;
        fill_map();
        read_map();
        wait_frame_end();

        // Every ROM answer at the latency limit
        @(posedge clk);
        flip     <= 1'b0;
        slow_rom = 1'b1;
        wait_frame_end();

        // New palette during vertical blanking
        slow_rom = 1'b0;
        fill_palette();
        wait_frame_end();

        if (UUT.u_asserts.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("A bound assertion on the ROM link or fetch timing failed");
        end
    end

endmodule

`default_nettype wire
